// File: vlog.f
+incdir+logic
logic/bridge_types_pkg.sv
logic/bridge_ctrl_pkg.sv
logic/cdc_fifo.sv
logic/wide_router.sv
logic/wide_downsizer.sv
logic/narrow_arbiter.sv
logic/cluster_bridge.sv
tb/bridge_checker.sv
tb/tb_cluster_bridge.sv

// File: run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
verilator --binary --timing -f vlog.f --top-module tb_cluster_bridge -o sim_bridge \
  > build.log 2>&1 &&
./obj_dir/sim_bridge > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0

// File: tb/tb_cluster_bridge.sv
/*
 * Testbench top: clocks, reset, random traffic on both
 * cluster ports, SoC back-pressure and the watchdog
 */

`include "bridge_defines.svh"

module tb_cluster_bridge;
  import bridge_types_pkg::*;

  localparam int N_MIX    = 40;  // Words per port with bypass low
  localparam int N_STALL  = 12;
  localparam int N_BYPASS = 16;
  localparam int TIMEOUT_CYC =
    200 * (2 * N_MIX + 2 * N_STALL + N_BYPASS / 2 + N_BYPASS) + 1000;

  logic soc_clk, clu_clk, arst_n, bypass;
  logic n_valid, n_ready, w_valid, w_ready;
  addr_t n_addr, w_addr;
  narrow_data_t n_data;
  wide_data_t w_data;
  logic no_valid, no_ready, wo_valid, wo_ready;
  addr_t no_addr, wo_addr;
  narrow_data_t no_data;
  wide_data_t wo_data;
  src_id_t no_id;
  int rdy_mode;  // 0 gives random ready and 1 stalls both
  int value_errs, proto_errs, pending;

  always #20 soc_clk = ~soc_clk;
  initial begin
    clu_clk = 1'b0;
    #13;
    forever #20 clu_clk = ~clu_clk;  // Kept out of phase
  end

  cluster_bridge UUT (
    .soc_clk_i(soc_clk), .clu_clk_i(clu_clk), .arst_n_i(arst_n), .widemem_bypass_i(bypass),
    .clu_narrow_valid_i(n_valid), .clu_narrow_addr_i(n_addr), .clu_narrow_data_i(n_data),
    .clu_narrow_ready_o(n_ready), .clu_wide_valid_i(w_valid), .clu_wide_addr_i(w_addr),
    .clu_wide_data_i(w_data), .clu_wide_ready_o(w_ready), .narrow_out_valid_o(no_valid),
    .narrow_out_addr_o(no_addr), .narrow_out_data_o(no_data), .narrow_out_id_o(no_id),
    .narrow_out_ready_i(no_ready), .wide_out_valid_o(wo_valid), .wide_out_addr_o(wo_addr),
    .wide_out_data_o(wo_data), .wide_out_ready_i(wo_ready)
  );

  bridge_checker i_checker (
    .soc_clk_i(soc_clk), .clu_clk_i(clu_clk), .arst_n_i(arst_n), .bypass_i(bypass),
    .clu_narrow_valid_i(n_valid), .clu_narrow_addr_i(n_addr), .clu_narrow_data_i(n_data),
    .clu_narrow_ready_i(n_ready), .clu_wide_valid_i(w_valid), .clu_wide_addr_i(w_addr),
    .clu_wide_data_i(w_data), .clu_wide_ready_i(w_ready), .narrow_valid_i(no_valid),
    .narrow_addr_i(no_addr), .narrow_data_i(no_data), .narrow_id_i(no_id),
    .narrow_ready_i(no_ready), .wide_valid_i(wo_valid), .wide_addr_i(wo_addr),
    .wide_data_i(wo_data), .wide_ready_i(wo_ready), .value_errs_o(value_errs),
    .proto_errs_o(proto_errs), .pending_o(pending)
  );

  // SoC back-pressure with ready high three times in four
  always @(posedge soc_clk) begin
    no_ready <= (rdy_mode == 0) && ($urandom % 4 != 0);
    wo_ready <= (rdy_mode == 0) && ($urandom % 4 != 0);
  end

  function automatic addr_t rand_addr(input logic in_region);
    if (in_region) return `BRIDGE_MEMISL_START + (($urandom % 32'h2_0000) & ~32'h7);
    return 32'h1000_0000 + (($urandom % 32'h10_0000) & ~32'h7);
  endfunction

  task automatic send_core(input int count);
    repeat (count) begin
      @(posedge clu_clk);
      n_valid <= 1'b1;
      n_addr  <= $urandom & ~32'h3;
      n_data  <= $urandom;
      do @(posedge clu_clk); while (!n_ready);
      n_valid <= 1'b0;
    end
  endtask

  task automatic send_wide(input int count);
    repeat (count) begin
      @(posedge clu_clk);
      w_valid <= 1'b1;
      w_addr  <= rand_addr(($urandom % 2) == 1);
      w_data  <= {$urandom, $urandom};
      do @(posedge clu_clk); while (!w_ready);
      w_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    do repeat (2) @(posedge soc_clk); while (pending != 0);
    repeat (5) @(posedge soc_clk);
  endtask

  initial begin
    void'($urandom(32'h45e9));
    soc_clk = 1'b0;
    arst_n = 1'b0;
    bypass = 1'b0;
    n_valid = 1'b0;
    n_addr = '0;
    n_data = '0;
    w_valid = 1'b0;
    w_addr = '0;
    w_data = '0;
    no_ready = 1'b0;
    wo_ready = 1'b0;
    rdy_mode = 0;
    repeat (5) @(posedge soc_clk);
    arst_n <= 1'b1;

    // Mixed traffic with bypass low
    fork
      send_core(N_MIX);
      send_wide(N_MIX);
    join
    wait_drain();

    // Full stall until both cluster ports push back
    rdy_mode <= 1;
    fork
      send_core(N_STALL);
      send_wide(N_STALL);
      begin
        logic seen_n;
        logic seen_w;
        seen_n = 1'b0;
        seen_w = 1'b0;
        while (!(seen_n && seen_w)) begin
          @(posedge soc_clk);
          seen_n = seen_n || !n_ready;
          seen_w = seen_w || !w_ready;
        end
        rdy_mode <= 0;
      end
    join
    wait_drain();

    // With bypass high the island words split as well
    @(posedge soc_clk);
    bypass <= 1'b1;
    fork
      send_core(N_BYPASS / 2);
      send_wide(N_BYPASS);
    join
    wait_drain();

    $display("Errors: value %0d, protocol %0d, outstanding words %0d",
             value_errs, proto_errs, pending);
    if (value_errs == 0 && proto_errs == 0 && pending == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge soc_clk);
    $display("Timeout: the bridge did not drain, %0d words still outstanding", pending);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: tb/bridge_checker.sv
/*
 * Scoreboard for the bridge: expected queues built from the
 * cluster-side handshakes, compared with both SoC ports
 */

`include "bridge_defines.svh"

module bridge_checker (
  input  logic                          soc_clk_i,
  input  logic                          clu_clk_i,
  input  logic                          arst_n_i,
  input  logic                          bypass_i,
  input  logic                          clu_narrow_valid_i,
  input  bridge_types_pkg::addr_t       clu_narrow_addr_i,
  input  bridge_types_pkg::narrow_data_t clu_narrow_data_i,
  input  logic                          clu_narrow_ready_i,
  input  logic                          clu_wide_valid_i,
  input  bridge_types_pkg::addr_t       clu_wide_addr_i,
  input  bridge_types_pkg::wide_data_t  clu_wide_data_i,
  input  logic                          clu_wide_ready_i,
  input  logic                          narrow_valid_i,
  input  bridge_types_pkg::addr_t       narrow_addr_i,
  input  bridge_types_pkg::narrow_data_t narrow_data_i,
  input  bridge_types_pkg::src_id_t     narrow_id_i,
  input  logic                          narrow_ready_i,
  input  logic                          wide_valid_i,
  input  bridge_types_pkg::addr_t       wide_addr_i,
  input  bridge_types_pkg::wide_data_t  wide_data_i,
  input  logic                          wide_ready_i,
  output int                            value_errs_o,
  output int                            proto_errs_o,
  output int                            pending_o
);
  import bridge_types_pkg::*;

  logic [63:0] core_q [$];  // {addr, data}
  logic [63:0] dma_q  [$];
  logic [95:0] wide_q [$];
  int          dma_beats;
  logic        n_stall_q;
  logic        w_stall_q;
  logic [64:0] n_held_q;    // {id, addr, data}
  logic [95:0] w_held_q;

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic route_of(input addr_t a, input logic bypass);
    return (a >= `BRIDGE_MEMISL_START) && (a < `BRIDGE_MEMISL_END) && !bypass;
  endfunction

  function automatic logic [63:0] split_of(input addr_t a, input wide_data_t d, input logic hi);
    if (hi) return {a + 32'd4, d[63:32]};
    return {a, d[31:0]};
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      value_errs_o++;
      $display("ERROR %s expected %h actual %h", name, exp, act);
    end
  endtask

  initial begin
    value_errs_o = 0;
    proto_errs_o = 0;
    pending_o    = 0;
    dma_beats    = 0;
  end

  always @(posedge clu_clk_i) begin
    if (arst_n_i && clu_narrow_valid_i && clu_narrow_ready_i)
      core_q.push_back({clu_narrow_addr_i, clu_narrow_data_i});
    if (arst_n_i && clu_wide_valid_i && clu_wide_ready_i) begin
      if (route_of(clu_wide_addr_i, bypass_i)) begin
        wide_q.push_back({clu_wide_addr_i, clu_wide_data_i});
      end else begin
        dma_q.push_back(split_of(clu_wide_addr_i, clu_wide_data_i, 1'b0));
        dma_q.push_back(split_of(clu_wide_addr_i, clu_wide_data_i, 1'b1));
      end
    end
  end

  // ------------------------------
  // SoC side comparison
  // ------------------------------
  always @(posedge soc_clk_i) begin
    logic [63:0] exp_n;
    logic [95:0] exp_w;
    if (!arst_n_i) begin
      n_stall_q <= 1'b0;
      w_stall_q <= 1'b0;
    end else begin
      // Held fields must not move under back-pressure
      if (n_stall_q && (!narrow_valid_i ||
          n_held_q !== {narrow_id_i, narrow_addr_i, narrow_data_i})) begin
        proto_errs_o++;
        $display("Narrow port changed while stalled at time %0t", $time);
      end
      if (w_stall_q && (!wide_valid_i || w_held_q !== {wide_addr_i, wide_data_i})) begin
        proto_errs_o++;
        $display("Wide port changed while stalled at time %0t", $time);
      end
      n_stall_q <= narrow_valid_i && !narrow_ready_i;
      w_stall_q <= wide_valid_i && !wide_ready_i;
      n_held_q  <= {narrow_id_i, narrow_addr_i, narrow_data_i};
      w_held_q  <= {wide_addr_i, wide_data_i};

      if (narrow_valid_i && narrow_ready_i) begin
        if (narrow_id_i == 1'b0 && dma_beats % 2 == 1) begin
          proto_errs_o++;
          $display("Core beat came between the two halves of a split word");
        end
        if ((narrow_id_i == 1'b0 ? core_q.size() : dma_q.size()) == 0) begin
          proto_errs_o++;
          $display("Narrow beat with id %0d arrived with nothing expected", narrow_id_i);
        end else begin
          exp_n = (narrow_id_i == 1'b0) ? core_q.pop_front() : dma_q.pop_front();
          compare("narrow_out_addr_o", {32'h0, exp_n[63:32]}, {32'h0, narrow_addr_i});
          compare("narrow_out_data_o", {32'h0, exp_n[31:0]}, {32'h0, narrow_data_i});
        end
        if (narrow_id_i == 1'b1) dma_beats++;
      end

      if (wide_valid_i && wide_ready_i) begin
        if (wide_q.size() == 0) begin
          proto_errs_o++;
          $display("Wide word arrived with nothing expected");
        end else begin
          exp_w = wide_q.pop_front();
          compare("wide_out_addr_o", {32'h0, exp_w[95:64]}, {32'h0, wide_addr_i});
          compare("wide_out_data_o", exp_w[63:0], wide_data_i);
        end
      end
    end
    pending_o = core_q.size() + dma_q.size() + wide_q.size();
  end

endmodule

// File: logic/cluster_bridge.sv
/*
 * Cluster to SoC write bridge: core and DMA CDC FIFOs,
 * wide router, downsizer and narrow port arbiter
 */

`include "bridge_defines.svh"

module cluster_bridge (
  input  logic                          soc_clk_i,
  input  logic                          clu_clk_i,
  input  logic                          arst_n_i,
  input  logic                          widemem_bypass_i,
  // Core port from the cluster
  input  logic                          clu_narrow_valid_i,
  input  bridge_types_pkg::addr_t       clu_narrow_addr_i,
  input  bridge_types_pkg::narrow_data_t clu_narrow_data_i,
  output logic                          clu_narrow_ready_o,
  // DMA port from the cluster
  input  logic                          clu_wide_valid_i,
  input  bridge_types_pkg::addr_t       clu_wide_addr_i,
  input  bridge_types_pkg::wide_data_t  clu_wide_data_i,
  output logic                          clu_wide_ready_o,
  // Narrow SoC port
  output logic                          narrow_out_valid_o,
  output bridge_types_pkg::addr_t       narrow_out_addr_o,
  output bridge_types_pkg::narrow_data_t narrow_out_data_o,
  output bridge_types_pkg::src_id_t     narrow_out_id_o,
  input  logic                          narrow_out_ready_i,
  // Wide SoC port
  output logic                          wide_out_valid_o,
  output bridge_types_pkg::addr_t       wide_out_addr_o,
  output bridge_types_pkg::wide_data_t  wide_out_data_o,
  input  logic                          wide_out_ready_i
);
  import bridge_types_pkg::*;

  // ------------------------------
  // SoC-side internal links
  // ------------------------------
  logic         core_valid, core_ready;
  addr_t        core_addr;
  narrow_data_t core_data;
  logic         dma_valid, dma_ready;
  addr_t        dma_addr;
  wide_data_t   dma_data;
  logic         split_valid, split_ready;
  addr_t        split_addr;
  wide_data_t   split_data;
  logic         beat_valid, beat_ready, beat_last;
  addr_t        beat_addr;
  narrow_data_t beat_data;

  cdc_fifo #(.DATA_W(`BRIDGE_ADDR_W + `BRIDGE_NARROW_W)) i_core_cdc (
    .wr_clk_i(clu_clk_i), .arst_n_i(arst_n_i), .wr_valid_i(clu_narrow_valid_i),
    .wr_data_i({clu_narrow_addr_i, clu_narrow_data_i}), .wr_ready_o(clu_narrow_ready_o),
    .rd_clk_i(soc_clk_i), .rd_valid_o(core_valid), .rd_data_o({core_addr, core_data}),
    .rd_ready_i(core_ready)
  );

  cdc_fifo #(.DATA_W(`BRIDGE_ADDR_W + `BRIDGE_WIDE_W)) i_dma_cdc (
    .wr_clk_i(clu_clk_i), .arst_n_i(arst_n_i), .wr_valid_i(clu_wide_valid_i),
    .wr_data_i({clu_wide_addr_i, clu_wide_data_i}), .wr_ready_o(clu_wide_ready_o),
    .rd_clk_i(soc_clk_i), .rd_valid_o(dma_valid), .rd_data_o({dma_addr, dma_data}),
    .rd_ready_i(dma_ready)
  );

  wide_router i_wide_router (
    .soc_clk_i, .arst_n_i, .in_valid_i(dma_valid), .in_addr_i(dma_addr),
    .in_data_i(dma_data), .in_ready_o(dma_ready), .bypass_i(widemem_bypass_i),
    .wide_valid_o(wide_out_valid_o), .wide_addr_o(wide_out_addr_o),
    .wide_data_o(wide_out_data_o), .wide_ready_i(wide_out_ready_i),
    .split_valid_o(split_valid), .split_addr_o(split_addr),
    .split_data_o(split_data), .split_ready_i(split_ready)
  );

  wide_downsizer i_wide_downsizer (
    .soc_clk_i, .arst_n_i, .in_valid_i(split_valid), .in_addr_i(split_addr),
    .in_data_i(split_data), .in_ready_o(split_ready), .out_valid_o(beat_valid),
    .out_addr_o(beat_addr), .out_data_o(beat_data), .out_last_o(beat_last),
    .out_ready_i(beat_ready)
  );

  narrow_arbiter i_narrow_arbiter (
    .soc_clk_i, .arst_n_i, .core_valid_i(core_valid), .core_addr_i(core_addr),
    .core_data_i(core_data), .core_ready_o(core_ready), .dma_valid_i(beat_valid),
    .dma_addr_i(beat_addr), .dma_data_i(beat_data), .dma_last_i(beat_last),
    .dma_ready_o(beat_ready), .out_valid_o(narrow_out_valid_o),
    .out_addr_o(narrow_out_addr_o), .out_data_o(narrow_out_data_o),
    .out_id_o(narrow_out_id_o), .out_ready_i(narrow_out_ready_i)
  );

endmodule

// File: logic/narrow_arbiter.sv
/*
 * Round-robin arbiter for the narrow SoC port, core vs
 * split DMA beats, locked across both beats of a split word
 */

module narrow_arbiter (
  input  logic                          soc_clk_i,
  input  logic                          arst_n_i,
  input  logic                          core_valid_i,
  input  bridge_types_pkg::addr_t       core_addr_i,
  input  bridge_types_pkg::narrow_data_t core_data_i,
  output logic                          core_ready_o,
  input  logic                          dma_valid_i,
  input  bridge_types_pkg::addr_t       dma_addr_i,
  input  bridge_types_pkg::narrow_data_t dma_data_i,
  input  logic                          dma_last_i,
  output logic                          dma_ready_o,
  output logic                          out_valid_o,
  output bridge_types_pkg::addr_t       out_addr_o,
  output bridge_types_pkg::narrow_data_t out_data_o,
  output bridge_types_pkg::src_id_t     out_id_o,
  input  logic                          out_ready_i
);
  import bridge_types_pkg::*;
  import bridge_ctrl_pkg::*;

  localparam src_id_t SRC_CORE = 1'b0;
  localparam src_id_t SRC_DMA  = 1'b1;

  arb_state_t state_q;
  src_id_t    last_winner_q;
  logic       core_hold_q;  // Core beat stalled on the port
  logic       grant_dma;

  // Grant stays put while a presented beat waits for ready
  always_comb begin
    if (state_q == ARB_LOCKED) grant_dma = 1'b1;
    else if (core_hold_q) grant_dma = 1'b0;
    else if (core_valid_i && dma_valid_i) grant_dma = (last_winner_q == SRC_CORE);
    else grant_dma = dma_valid_i;
  end

  assign out_valid_o  = grant_dma ? dma_valid_i : core_valid_i;
  assign out_addr_o   = grant_dma ? dma_addr_i : core_addr_i;
  assign out_data_o   = grant_dma ? dma_data_i : core_data_i;
  assign out_id_o     = grant_dma ? SRC_DMA : SRC_CORE;
  assign core_ready_o = !grant_dma && out_ready_i;
  assign dma_ready_o  = grant_dma && out_ready_i;

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= ARB_FREE;
      last_winner_q <= SRC_DMA;  // Core goes first
      core_hold_q   <= 1'b0;
    end else begin
      core_hold_q <= !grant_dma && core_valid_i && !out_ready_i;
      if (out_valid_o && out_ready_i) last_winner_q <= out_id_o;
      if (grant_dma && dma_valid_i) begin
        state_q <= (dma_last_i && out_ready_i) ? ARB_FREE : ARB_LOCKED;
      end
    end
  end

endmodule

// File: logic/wide_downsizer.sv
/*
 * Wide to narrow downsizer: one 64-bit word becomes two
 * 32-bit beats, low half first
 */

`include "bridge_defines.svh"

module wide_downsizer (
  input  logic                          soc_clk_i,
  input  logic                          arst_n_i,
  input  logic                          in_valid_i,
  input  bridge_types_pkg::addr_t       in_addr_i,
  input  bridge_types_pkg::wide_data_t  in_data_i,
  output logic                          in_ready_o,
  output logic                          out_valid_o,
  output bridge_types_pkg::addr_t       out_addr_o,
  output bridge_types_pkg::narrow_data_t out_data_o,
  output logic                          out_last_o,
  input  logic                          out_ready_i
);
  import bridge_types_pkg::*;
  import bridge_ctrl_pkg::*;

  split_state_t state_q;
  split_state_t state_d;
  addr_t        addr_q;
  wide_data_t   data_q;

  assign in_ready_o = (state_q == SPLIT_IDLE);

  // ------------------------------
  // State machine
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      SPLIT_IDLE: if (in_valid_i) state_d = SPLIT_LOW;
      SPLIT_LOW:  if (out_ready_i) state_d = SPLIT_HIGH;
      SPLIT_HIGH: if (out_ready_i) state_d = SPLIT_IDLE;
      default:    state_d = SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SPLIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (in_valid_i && in_ready_o) begin
      addr_q <= in_addr_i;
      data_q <= in_data_i;
    end
  end

  // Beat select
  assign out_valid_o = (state_q == SPLIT_LOW) || (state_q == SPLIT_HIGH);
  assign out_last_o  = (state_q == SPLIT_HIGH);
  assign out_addr_o  = out_last_o ? addr_q + addr_t'(`BRIDGE_BEAT_BYTES) : addr_q;
  assign out_data_o  = out_last_o ? data_q[`BRIDGE_WIDE_W-1:`BRIDGE_NARROW_W]
                                  : data_q[`BRIDGE_NARROW_W-1:0];

endmodule

// File: logic/wide_router.sv
/*
 * Wide request router: memory-island decode with bypass,
 * output register toward the wide SoC port
 */

`include "bridge_defines.svh"

module wide_router (
  input  logic                        soc_clk_i,
  input  logic                        arst_n_i,
  input  logic                        in_valid_i,
  input  bridge_types_pkg::addr_t     in_addr_i,
  input  bridge_types_pkg::wide_data_t in_data_i,
  output logic                        in_ready_o,
  input  logic                        bypass_i,
  output logic                        wide_valid_o,
  output bridge_types_pkg::addr_t     wide_addr_o,
  output bridge_types_pkg::wide_data_t wide_data_o,
  input  logic                        wide_ready_i,
  output logic                        split_valid_o,
  output bridge_types_pkg::addr_t     split_addr_o,
  output bridge_types_pkg::wide_data_t split_data_o,
  input  logic                        split_ready_i
);
  import bridge_types_pkg::*;

  localparam addr_t REGION_START = `BRIDGE_MEMISL_START;
  localparam addr_t REGION_END   = `BRIDGE_MEMISL_END;

  logic       to_wide;
  logic       reg_free;
  logic       wide_valid_q;
  addr_t      wide_addr_q;
  wide_data_t wide_data_q;

  // Pass-through only inside the island and with bypass low
  assign to_wide  = (in_addr_i >= REGION_START) && (in_addr_i < REGION_END) && !bypass_i;
  assign reg_free = !wide_valid_q || wide_ready_i;

  assign in_ready_o    = to_wide ? reg_free : split_ready_i;
  assign split_valid_o = in_valid_i && !to_wide;
  assign split_addr_o  = in_addr_i;
  assign split_data_o  = in_data_i;

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wide_valid_q <= 1'b0;
    end else if (in_valid_i && to_wide && reg_free) begin
      wide_valid_q <= 1'b1;
    end else if (wide_ready_i) begin
      wide_valid_q <= 1'b0;  // Drained, nothing new
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (in_valid_i && to_wide && reg_free) begin
      wide_addr_q <= in_addr_i;
      wide_data_q <= in_data_i;
    end
  end

  assign wide_valid_o = wide_valid_q;
  assign wide_addr_o  = wide_addr_q;
  assign wide_data_o  = wide_data_q;

endmodule

// File: logic/cdc_fifo.sv
/*
 * Asynchronous FIFO with gray-coded pointers and two-flop
 * synchronizers in each direction
 */

`include "bridge_defines.svh"

module cdc_fifo #(
  parameter int unsigned DATA_W = 64
) (
  // Write side
  input  logic              wr_clk_i,
  input  logic              arst_n_i,
  input  logic              wr_valid_i,
  input  logic [DATA_W-1:0] wr_data_i,
  output logic              wr_ready_o,
  // Read side
  input  logic              rd_clk_i,
  output logic              rd_valid_o,
  output logic [DATA_W-1:0] rd_data_o,
  input  logic              rd_ready_i
);

  localparam int unsigned PTR_W = `BRIDGE_FIFO_LOG_DEPTH;
  localparam int unsigned DEPTH = 1 << PTR_W;

  function automatic logic [PTR_W:0] bin2gray(input logic [PTR_W:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  logic [DATA_W-1:0] mem_q [DEPTH];

  logic [PTR_W:0] wr_bin_q;
  logic [PTR_W:0] wr_bin_d;
  logic [PTR_W:0] wr_gray_q;
  logic [PTR_W:0] rd_bin_q;
  logic [PTR_W:0] rd_bin_d;
  logic [PTR_W:0] rd_gray_q;
  logic [PTR_W:0] rd_gray_w1_q;  // Read pointer in the write domain
  logic [PTR_W:0] rd_gray_w2_q;
  logic [PTR_W:0] wr_gray_r1_q;  // Write pointer in the read domain
  logic [PTR_W:0] wr_gray_r2_q;
  logic           wr_push;
  logic           rd_pop;

  // ------------------------------
  // Write domain
  // ------------------------------
  assign wr_ready_o = wr_gray_q != {~rd_gray_w2_q[PTR_W:PTR_W-1], rd_gray_w2_q[PTR_W-2:0]};
  assign wr_push    = wr_valid_i && wr_ready_o;
  assign wr_bin_d   = wr_bin_q + {{PTR_W{1'b0}}, wr_push};

  always_ff @(posedge wr_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_bin_q     <= '0;
      wr_gray_q    <= '0;
      rd_gray_w1_q <= '0;
      rd_gray_w2_q <= '0;
    end else begin
      wr_bin_q     <= wr_bin_d;
      wr_gray_q    <= bin2gray(wr_bin_d);
      rd_gray_w1_q <= rd_gray_q;
      rd_gray_w2_q <= rd_gray_w1_q;
    end
  end

  always_ff @(posedge wr_clk_i) begin
    if (wr_push) begin
      mem_q[wr_bin_q[PTR_W-1:0]] <= wr_data_i;
    end
  end

  // ------------------------------
  // Read domain
  // ------------------------------
  assign rd_valid_o = rd_gray_q != wr_gray_r2_q;  // Empty when pointers match
  assign rd_data_o  = mem_q[rd_bin_q[PTR_W-1:0]];
  assign rd_pop     = rd_valid_o && rd_ready_i;
  assign rd_bin_d   = rd_bin_q + {{PTR_W{1'b0}}, rd_pop};

  always_ff @(posedge rd_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_bin_q     <= '0;
      rd_gray_q    <= '0;
      wr_gray_r1_q <= '0;
      wr_gray_r2_q <= '0;
    end else begin
      rd_bin_q     <= rd_bin_d;
      rd_gray_q    <= bin2gray(rd_bin_d);
      wr_gray_r1_q <= wr_gray_q;
      wr_gray_r2_q <= wr_gray_r1_q;
    end
  end

endmodule

// File: logic/bridge_ctrl_pkg.sv
/*
 * Control encodings: downsizer and arbiter FSM states
 */

package bridge_ctrl_pkg;

  typedef enum logic [1:0] {
    SPLIT_IDLE = 2'd0,  // Waiting for a wide word
    SPLIT_LOW  = 2'd1,  // Low half on the output
    SPLIT_HIGH = 2'd2   // High half, last beat
  } split_state_t;

  typedef enum logic {
    ARB_FREE   = 1'b0,
    ARB_LOCKED = 1'b1   // Held for the DMA high beat
  } arb_state_t;

endpackage

// File: logic/bridge_types_pkg.sv
/*
 * Data types of the bridge: addresses, narrow and
 * wide words, and the source tag on the narrow port
 */

`include "bridge_defines.svh"

package bridge_types_pkg;

  typedef logic [`BRIDGE_ADDR_W-1:0]   addr_t;
  typedef logic [`BRIDGE_NARROW_W-1:0] narrow_data_t;
  typedef logic [`BRIDGE_WIDE_W-1:0]   wide_data_t;

  // 0 for the core port, 1 for DMA
  typedef logic [0:0]                  src_id_t;

endpackage

// File: logic/bridge_defines.svh
/*
 * Bridge dimensions: bus widths, CDC FIFO depth,
 * memory-island window and split beat step
 */

`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// Bus widths
`define BRIDGE_ADDR_W         32
`define BRIDGE_NARROW_W       32
`define BRIDGE_WIDE_W         64

`define BRIDGE_FIFO_LOG_DEPTH 3  // 8 entries per CDC FIFO

// Memory-island window, end is exclusive
`define BRIDGE_MEMISL_START   32'h4800_0000
`define BRIDGE_MEMISL_END     32'h4802_0000
`define BRIDGE_BEAT_BYTES     4  // Address step of the high beat

`endif
